// ==== verif/rtfifo_tests.txt ====
# op W/R/F, fifo T/R, hex value: write word, head before read, or flags
# flags value bits are txEmpty txFull rxEmpty rxFull
F T a
R T 00
R R 00
W T 11
W R a1
W T 12
W T 13
W T 14
W R a2
W T 15
W T 16
W T 17
W T 18
W T 19
W T 1a
W R a3
W T 1b
W T 1c
W T 1d
W T 1e
W T 1f
W T 20
W T 21
F T 4
W T 22
R T 11
R R a1
R T 12
R T 13
R T 14
R R a2
R T 15
R T 16
R T 17
R T 18
R T 19
R T 1a
R T 1b
R T 1c
R R a3
R T 1d
R T 1e
R T 1f
R T 20
R T 21
F T a
R T 21
R R a3

// ==== tb.f ====
+incdir+rtl
rtl/rtFifoPkg.sv
rtl/fifoCmdLatch.sv
rtl/fifoSequencer.sv
rtl/fifoPointerFile.sv
rtl/fifoStore.sv
rtl/fifoFlags.sv
rtl/rtFifo.sv
verif/clockGen.sv
verif/rtFifoTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rtFifoTb -f tb.f -o simv &&
./obj_dir/simv 2>&1 | tee /dev/stderr | grep -q "^Simulation completed successfully$" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

// ==== verif/rtFifoTb.sv ====
`include "rtfifo_defines.svh"

module rtFifoTb;

    localparam int SettleCycles  = 20;              // Strobe to stable heads and flags
    localparam int CyclesPerLine = 40;
    localparam int Capacity      = `RTF_DEPTH + 1;  // Head register plus one RAM half

    logic               Clk;
    logic               rstN;
    logic               TfWr, TfRd, RfWr, RfRd;
    rtFifoPkg::dataT    Tdi, Rdi;
    rtFifoPkg::dataT    Tdo, Rdo;
    rtFifoPkg::flagsT   flags;

    logic [7:0]         opList[$];                  // Parsed test lines
    logic [7:0]         fifoList[$];
    logic [7:0]         valList[$];

    rtFifoPkg::dataT    txModel[$];                 // Reference FIFOs
    rtFifoPkg::dataT    rxModel[$];
    rtFifoPkg::dataT    txHead, rxHead;             // Last word each output shows

    logic [31:0]        lfsrState;
    int                 errCount   = 0;
    int                 cycleCount = 0;
    int                 cycleLimit = 100000;        // Replaced once the tests are loaded

    clockGen u_clk (.Clk(Clk), .rstN(rstN));

    rtFifo u_dut (
        .Clk(Clk), .rstN(rstN),
        .TfWr(TfWr), .TfRd(TfRd), .RfWr(RfWr), .RfRd(RfRd),
        .Tdi(Tdi), .Rdi(Rdi), .Tdo(Tdo), .Rdo(Rdo), .flags(flags)
    );

    //////////////////////////////////////////////////
    // Failure, compares, timeout
    //////////////////////////////////////////////////

    task automatic endWithFailure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkData(input rtFifoPkg::dataT got, input rtFifoPkg::dataT exp,
                             input string what);
        if (got !== exp)
        begin
            errCount++;
            $display("FAIL at time %0t: %s is %h, expected %h", $time, what, got, exp);
            endWithFailure();
        end
    endtask

    task automatic checkFlags(input rtFifoPkg::flagsT got, input rtFifoPkg::flagsT exp);
        if (got !== exp)
        begin
            errCount++;
            $display("FAIL at time %0t: flags {txE,txF,rxE,rxF} are %b, expected %b",
                     $time, got, exp);
            endWithFailure();
        end
    endtask

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: no end of test after %0d cycles", cycleCount);
            endWithFailure();
        end
    end

    //////////////////////////////////////////////////
    // Reference model and stimulus
    //////////////////////////////////////////////////

    // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    function automatic rtFifoPkg::flagsT modelFlags();
        rtFifoPkg::flagsT f;
        f.txEmpty = (txModel.size() == 0);
        f.txFull  = (txModel.size() == Capacity);
        f.rxEmpty = (rxModel.size() == 0);
        f.rxFull  = (rxModel.size() == Capacity);
        return f;
    endfunction

    task automatic waitSettle();
        int gap;
        gap = 0;
        for (int i = 0; i < 3; i++)
        begin
            gap = (gap << 1) | int'(lfsrState[0]);      // One step per bit
            lfsrState = lfsrStep(lfsrState);
        end
        repeat (SettleCycles + gap) @(posedge Clk);
        @(negedge Clk);                                 // Sample away from the edge
    endtask

    task automatic checkOutputs();
        checkData(Tdo, txHead, "Tdo");
        checkData(Rdo, rxHead, "Rdo");
        checkFlags(flags, modelFlags());
    endtask

    task automatic writeWord(input logic isTx, input rtFifoPkg::dataT d);
        @(posedge Clk);
        if (isTx)
        begin
            Tdi  <= d;                                  // Held until the next TX write
            TfWr <= 1'b1;
        end
        else
        begin
            Rdi  <= d;
            RfWr <= 1'b1;
        end
        @(posedge Clk);
        TfWr <= 1'b0;
        RfWr <= 1'b0;
        // Full FIFO drops the write; first word falls through
        if (isTx && txModel.size() < Capacity)
        begin
            if (txModel.size() == 0)
                txHead = d;
            txModel.push_back(d);
        end
        else if (!isTx && rxModel.size() < Capacity)
        begin
            if (rxModel.size() == 0)
                rxHead = d;
            rxModel.push_back(d);
        end
    endtask

    task automatic readWord(input logic isTx);
        @(posedge Clk);
        if (isTx)
            TfRd <= 1'b1;
        else
            RfRd <= 1'b1;
        @(posedge Clk);
        TfRd <= 1'b0;
        RfRd <= 1'b0;
        // Empty FIFO ignores it, last word stays on the output
        if (isTx && txModel.size() > 0)
        begin
            void'(txModel.pop_front());
            if (txModel.size() > 0)
                txHead = txModel[0];
        end
        else if (!isTx && rxModel.size() > 0)
        begin
            void'(rxModel.pop_front());
            if (rxModel.size() > 0)
                rxHead = rxModel[0];
        end
    endtask

    //////////////////////////////////////////////////
    // Tests file
    //////////////////////////////////////////////////

    task automatic loadTests();
        int              fd;
        int              code;
        logic [7:0]      op;
        logic [7:0]      fifo;
        logic [7:0]      val;
        logic [8*80-1:0] rest;
        fd = $fopen("verif/rtfifo_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verif/rtfifo_tests.txt");
            endWithFailure();
        end
        while (!$feof(fd))
        begin
            op   = 8'h00;
            code = $fscanf(fd, "%s", op);
            if (code != 1)
                break;                                  // Trailing blank text
            if (op == "#")
                code = $fgets(rest, fd);                // Rest of a comment line
            else
            begin
                code = $fscanf(fd, "%s %h", fifo, val);
                if (code != 2 || (fifo != "T" && fifo != "R"))
                begin
                    $display("Malformed line %0d in tests file", opList.size() + 1);
                    endWithFailure();
                end
                opList.push_back(op);
                fifoList.push_back(fifo);
                valList.push_back(val);
            end
        end
        $fclose(fd);
    endtask

    task automatic runLine(input logic [7:0] op, input logic [7:0] fifo,
                           input logic [7:0] val);
        logic isTx;
        isTx = (fifo == "T");
        case (op)
            "W":
            begin
                writeWord(isTx, val);
                waitSettle();
                checkOutputs();
            end
            "R":
            begin
                checkData(isTx ? Tdo : Rdo, val, "head before read");
                readWord(isTx);
                waitSettle();
                checkOutputs();
            end
            "F": checkFlags(flags, rtFifoPkg::flagsT'(val[3:0]));   // Value from the file
            default:
            begin
                $display("Unknown opcode in tests file");
                endWithFailure();
            end
        endcase
    endtask

    initial
    begin
        TfWr <= 1'b0;
        TfRd <= 1'b0;
        RfWr <= 1'b0;
        RfRd <= 1'b0;
        Tdi  <= '0;
        Rdi  <= '0;
        lfsrState = 32'h72ee;
        txHead    = '0;                                 // Reset value of both heads
        rxHead    = '0;
        loadTests();
        cycleLimit = opList.size() * CyclesPerLine;
        wait (rstN === 1'b1);
        @(negedge Clk);
        checkOutputs();                                 // State right after reset
        for (int i = 0; i < opList.size(); i++)
            runLine(opList[i], fifoList[i], valList[i]);
        if (errCount == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            endWithFailure();
        end
    end

endmodule

// ==== verif/clockGen.sv ====
module clockGen
(
    output logic Clk,
    output logic rstN
);

    // Free-running clock, period 10
    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Reset held low for the first two rising edges
    initial
    begin
        rstN <= 1'b0;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;                       // Released on an edge
    end

endmodule

// ==== rtl/rtFifo.sv ====
`include "rtfifo_defines.svh"

module rtFifo
(
    input  logic              Clk,
    input  logic              rstN,
    input  logic              TfWr,
    input  logic              TfRd,
    input  logic              RfWr,
    input  logic              RfRd,
    input  rtFifoPkg::dataT   Tdi,
    input  rtFifoPkg::dataT   Rdi,
    output rtFifoPkg::dataT   Tdo,
    output rtFifoPkg::dataT   Rdo,
    output rtFifoPkg::flagsT  flags
);

    rtFifoPkg::fifoReqT              req;
    rtFifoPkg::fifoDoneT             done;
    rtFifoPkg::ctrlWordT             ctrl;
    logic [`RTF_ADDR_BITS-1:0]       ptr;
    logic                            zero;

    //////////////////////////////////////////////////
    // Request latch and sequencer
    //////////////////////////////////////////////////

    fifoCmdLatch u_cmdLatch (
        .Clk(Clk), .rstN(rstN),
        .TfWr(TfWr), .TfRd(TfRd), .RfWr(RfWr), .RfRd(RfRd),
        .flags(flags), .done(done), .req(req)
    );

    fifoSequencer u_sequencer (
        .Clk(Clk), .rstN(rstN),
        .req(req), .flags(flags), .zero(zero),
        .ctrl(ctrl), .done(done)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    fifoPointerFile u_pointerFile (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .ptr(ptr), .zero(zero)
    );

    fifoStore u_store (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .ptr(ptr),
        .Tdi(Tdi), .Rdi(Rdi), .Tdo(Tdo), .Rdo(Rdo)
    );

    fifoFlags u_flags (
        .Clk(Clk), .rstN(rstN), .ctrl(ctrl), .zero(zero), .flags(flags)
    );

endmodule

// ==== rtl/fifoFlags.sv ====
module fifoFlags
(
    input  logic                 Clk,
    input  logic                 rstN,
    input  rtFifoPkg::ctrlWordT  ctrl,
    input  logic                 zero,
    output rtFifoPkg::flagsT     flags
);

    logic hitTx, hitRx;

    assign hitTx = (ctrl.sel == rtFifoPkg::Tx);
    assign hitRx = (ctrl.sel == rtFifoPkg::Rx);

    // Next {empty, full} of one FIFO
    function automatic logic [1:0] nextFlags(input logic hit, input logic empty,
                                             input logic full,
                                             input rtFifoPkg::ctrlWordT cw,
                                             input logic isZero);
        logic e;
        logic f;
        e = empty;
        f = full;
        if (hit && cw.clrEmpty) e = 1'b0;
        if (hit && cw.setEmpty)
        begin
            e = isZero;                 // No word left behind the head
            f = 1'b0;                   // Any read drops full
        end
        if (hit && cw.setFull) f = isZero;
        return {e, f};
    endfunction

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            flags <= '{txEmpty: 1'b1, txFull: 1'b0, rxEmpty: 1'b1, rxFull: 1'b0};
        end
        else
        begin
            {flags.txEmpty, flags.txFull} <= nextFlags(hitTx, flags.txEmpty, flags.txFull,
                                                       ctrl, zero);
            {flags.rxEmpty, flags.rxFull} <= nextFlags(hitRx, flags.rxEmpty, flags.rxFull,
                                                       ctrl, zero);
        end
    end

    // Count, sequencer and flags must agree
    assert property (@(posedge Clk) disable iff (!rstN)
        !(flags.txEmpty && flags.txFull) && !(flags.rxEmpty && flags.rxFull));

endmodule

// ==== rtl/fifoStore.sv ====
`include "rtfifo_defines.svh"

module fifoStore
(
    input  logic                        Clk,
    input  logic                        rstN,
    input  rtFifoPkg::ctrlWordT         ctrl,
    input  logic [`RTF_ADDR_BITS-1:0]   ptr,
    input  rtFifoPkg::dataT             Tdi,
    input  rtFifoPkg::dataT             Rdi,
    output rtFifoPkg::dataT             Tdo,    // TX head
    output rtFifoPkg::dataT             Rdo     // RX head
);

    localparam int RamWords = 2 * `RTF_DEPTH;   // Rx half low, Tx half high

    rtFifoPkg::dataT           ram [RamWords];
    logic [`RTF_ADDR_BITS:0]   addr;
    rtFifoPkg::dataT           wrData;
    rtFifoPkg::dataT           rdData;
    logic                      loadTx, loadRx;

    assign addr   = {ctrl.sel, ptr};
    assign wrData = (ctrl.sel == rtFifoPkg::Tx) ? Tdi : Rdi;

    //////////////////////////////////////////////////
    // Shared RAM, write-first
    //////////////////////////////////////////////////

    always_ff @(posedge Clk)
    begin
        if (ctrl.ramWr)
        begin
            ram[addr] <= wrData;
            rdData    <= wrData;                // Forward for fall-through
        end
        else
        begin
            rdData <= ram[addr];
        end
    end

    // Load strobes lag the RAM access by one cycle
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            loadTx <= 1'b0;
            loadRx <= 1'b0;
            Tdo    <= '0;
            Rdo    <= '0;
        end
        else
        begin
            loadTx <= ctrl.loadOut & (ctrl.sel == rtFifoPkg::Tx);
            loadRx <= ctrl.loadOut & (ctrl.sel == rtFifoPkg::Rx);
            if (loadTx) Tdo <= rdData;
            if (loadRx) Rdo <= rdData;
        end
    end

endmodule

// ==== rtl/fifoPointerFile.sv ====
`include "rtfifo_defines.svh"

module fifoPointerFile
(
    input  logic                        Clk,
    input  logic                        rstN,
    input  rtFifoPkg::ctrlWordT         ctrl,
    output logic [`RTF_ADDR_BITS-1:0]   ptr,    // Selected entry, RAM address
    output logic                        zero
);

    // One extra bit so the count can hold DEPTH
    localparam int EntryBits = `RTF_ADDR_BITS + 1;

    logic [EntryBits-1:0] regFile [2][3];       // [fifo][WordCount/ReadPtr/WritePtr]
    logic [EntryBits-1:0] cur;
    logic [EntryBits-1:0] result;

    assign cur = regFile[ctrl.sel][ctrl.regSel];
    assign ptr = cur[`RTF_ADDR_BITS-1:0];

    //////////////////////////////////////////////////
    // Inc/dec unit
    //////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.op)
            rtFifoPkg::Inc: result = cur + 1'b1;
            rtFifoPkg::Dec: result = cur - EntryBits'(|cur);    // Stops at zero
            default:        result = cur;
        endcase
    end

    // Inc: low bits wrapped, count reached DEPTH
    // Dec: count was already zero
    assign zero = (ctrl.op == rtFifoPkg::Inc) ? (result[`RTF_ADDR_BITS-1:0] == '0)
                                              : (cur == '0);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int f = 0; f < 2; f++)
            begin
                for (int r = 0; r < 3; r++)
                begin
                    regFile[f][r] <= '0;
                end
            end
        end
        else if (ctrl.op != rtFifoPkg::Hold)
        begin
            regFile[ctrl.sel][ctrl.regSel] <= result;   // Write back
        end
    end

endmodule

// ==== rtl/fifoSequencer.sv ====
module fifoSequencer
(
    input  logic                 Clk,
    input  logic                 rstN,
    input  rtFifoPkg::fifoReqT   req,
    input  rtFifoPkg::flagsT     flags,
    input  logic                 zero,     // Word count was zero (Rd)
    output rtFifoPkg::ctrlWordT  ctrl,
    output rtFifoPkg::fifoDoneT  done
);

    rtFifoPkg::seqStateE state, nextState;
    rtFifoPkg::fifoSelE  sel, nextSel;
    logic                isTx;
    logic                wrDone, rdDone;

    //////////////////////////////////////////////////
    // Next state and priority encoder
    //////////////////////////////////////////////////

    always_comb
    begin
        nextState = rtFifoPkg::Idle;
        nextSel   = sel;
        case (state)
            rtFifoPkg::Idle:
            begin
                // TX write, RX read, TX read, RX write
                if (req.txWr)
                begin
                    nextSel   = rtFifoPkg::Tx;
                    nextState = flags.txEmpty ? rtFifoPkg::WrEmpty : rtFifoPkg::Wr;
                end
                else if (req.rxRd)
                begin
                    nextSel   = rtFifoPkg::Rx;
                    nextState = rtFifoPkg::Rd;
                end
                else if (req.txRd)
                begin
                    nextSel   = rtFifoPkg::Tx;
                    nextState = rtFifoPkg::Rd;
                end
                else if (req.rxWr)
                begin
                    nextSel   = rtFifoPkg::Rx;
                    nextState = flags.rxEmpty ? rtFifoPkg::WrEmpty : rtFifoPkg::Wr;
                end
            end
            rtFifoPkg::Wr: nextState = rtFifoPkg::WrCount;
            rtFifoPkg::Rd: nextState = zero ? rtFifoPkg::Idle : rtFifoPkg::RdLoad;  // Last word
            default:       nextState = rtFifoPkg::Idle;      // WrEmpty, WrCount, RdLoad
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= rtFifoPkg::Idle;
            sel   <= rtFifoPkg::Rx;
        end
        else
        begin
            state <= nextState;
            sel   <= nextSel;       // Held through the sequence
        end
    end

    //////////////////////////////////////////////////
    // Control word decode
    //////////////////////////////////////////////////

    always_comb
    begin
        ctrl     = '0;              // Hold and no strobes
        ctrl.sel = sel;
        case (state)
            rtFifoPkg::WrEmpty:
            begin
                ctrl.regSel   = rtFifoPkg::WritePtr;  // Pointer not advanced
                ctrl.ramWr    = 1'b1;
                ctrl.loadOut  = 1'b1;                 // Forward straight to head
                ctrl.clrEmpty = 1'b1;
            end
            rtFifoPkg::Wr:
            begin
                ctrl.regSel = rtFifoPkg::WritePtr;
                ctrl.op     = rtFifoPkg::Inc;
                ctrl.ramWr  = 1'b1;
            end
            rtFifoPkg::WrCount:
            begin
                ctrl.regSel  = rtFifoPkg::WordCount;
                ctrl.op      = rtFifoPkg::Inc;
                ctrl.setFull = 1'b1;                  // On wrap to DEPTH
            end
            rtFifoPkg::Rd:
            begin
                ctrl.regSel   = rtFifoPkg::WordCount;
                ctrl.op       = rtFifoPkg::Dec;
                ctrl.setEmpty = 1'b1;                 // Old count tested
            end
            rtFifoPkg::RdLoad:
            begin
                ctrl.regSel  = rtFifoPkg::ReadPtr;
                ctrl.op      = rtFifoPkg::Inc;
                ctrl.loadOut = 1'b1;
            end
            default: ;
        endcase
    end

    // Done strobes clear the latched request before the next Idle
    assign isTx   = (sel == rtFifoPkg::Tx);
    assign wrDone = (state == rtFifoPkg::WrEmpty) || (state == rtFifoPkg::WrCount);
    assign rdDone = (state == rtFifoPkg::Rd);

    assign done.txWr = wrDone & isTx;
    assign done.txRd = rdDone & isTx;
    assign done.rxWr = wrDone & ~isTx;
    assign done.rxRd = rdDone & ~isTx;

    // Head load from RAM only while the served FIFO still holds words
    assert property (@(posedge Clk) disable iff (!rstN)
        (state == rtFifoPkg::RdLoad) |-> (isTx ? !flags.txEmpty : !flags.rxEmpty));

endmodule

// ==== rtl/fifoCmdLatch.sv ====
module fifoCmdLatch
(
    input  logic               Clk,
    input  logic               rstN,
    input  logic               TfWr,    // TX write strobe
    input  logic               TfRd,    // TX read strobe
    input  logic               RfWr,    // RX write strobe
    input  logic               RfRd,    // RX read strobe
    input  rtFifoPkg::flagsT   flags,
    input  rtFifoPkg::fifoDoneT done,
    output rtFifoPkg::fifoReqT req
);

    logic setTxWr, setTxRd, setRxWr, setRxRd;

    // Full blocks writes, empty blocks reads
    assign setTxWr = TfWr & ~flags.txFull;
    assign setTxRd = TfRd & ~flags.txEmpty;
    assign setRxWr = RfWr & ~flags.rxFull;
    assign setRxRd = RfRd & ~flags.rxEmpty;

    //////////////////////////////////////////////////
    // Pending requests, set wins over done
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            req <= '0;
        end
        else
        begin
            req.txWr <= setTxWr | (req.txWr & ~done.txWr);
            req.txRd <= setTxRd | (req.txRd & ~done.txRd);
            req.rxWr <= setRxWr | (req.rxWr & ~done.rxWr);
            req.rxRd <= setRxRd | (req.rxRd & ~done.rxRd);  // Merges a repeat strobe
        end
    end

endmodule

// ==== rtl/rtFifoPkg.sv ====
`include "rtfifo_defines.svh"

package rtFifoPkg;

    typedef enum logic {Rx, Tx} fifoSelE;                  // FIFO being served

    typedef enum logic [2:0] {
        Idle, WrEmpty, Wr, WrCount, Rd, RdLoad
    } seqStateE;

    typedef enum logic [1:0] {WordCount, ReadPtr, WritePtr} regSelE;
    typedef enum logic [1:0] {Hold, Inc, Dec} aluOpE;     // Pointer file unit op

    typedef logic [`RTF_DATA_BITS-1:0] dataT;

    typedef struct packed {logic txWr; logic txRd; logic rxWr; logic rxRd;} fifoReqT;
    typedef struct packed {logic txWr; logic txRd; logic rxWr; logic rxRd;} fifoDoneT;
    typedef struct packed {logic txEmpty; logic txFull; logic rxEmpty; logic rxFull;} flagsT;

    // Decoded control word, one per sequencer state
    typedef struct packed {
        fifoSelE sel;       // FIFO half
        regSelE  regSel;    // Pointer file entry
        aluOpE   op;        // Inc/dec unit
        logic    ramWr;     // Write RAM, forward to read data
        logic    loadOut;   // Load head register next cycle
        logic    setEmpty;  // Empty <= zero, full drops
        logic    setFull;   // Full <= zero
        logic    clrEmpty;  // Head now valid
    } ctrlWordT;

endpackage

// ==== rtl/rtfifo_defines.svh ====
`ifndef RTFIFO_DEFINES_SVH
`define RTFIFO_DEFINES_SVH

//////////////////////////////////////////////////
// Sizing of the shared TX/RX FIFO pair
//////////////////////////////////////////////////

// Pointer width of each FIFO half
`define RTF_ADDR_BITS 4

// Width of one data word
`define RTF_DATA_BITS 8

// Words per FIFO half of the shared RAM
`define RTF_DEPTH (1 << `RTF_ADDR_BITS)

`endif
